// File: list.f
source/classifier_pkg.sv
source/frame_capture.sv
source/bin_fifo.sv
source/decision_unit.sv
source/classifier_top.sv
test/classifier_properties.sv
test/tb_classifier.sv

// File: Makefile
TOP := tb_classifier

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir

// File: test/tb_classifier.sv
//==============================
// Testbench for the tone classifier, directed and random frames
// checked against a reference model, run from the Makefile
//==============================

`timescale 1ns/1ps

module tb_classifier import classifier_pkg::*; ();

  localparam int N_BINS     = 8;
  localparam int FIFO_DEPTH = 4;
  localparam int TIMEOUT    = 200;

  typedef bin_t [N_BINS-1:0] frame_t;

  logic      clk = 1'b0;
  logic      reset;
  logic      frame_val;
  logic      frame_rdy;
  frame_t    frame_msg;
  logic      cfg_val;
  logic      cfg_rdy;
  cfg_t      cfg_msg;
  logic      result_val;
  logic      result_rdy;
  decision_t result_msg;
  cfg_t      cur_cfg;

  classifier_top #(
    .N_BINS    (N_BINS),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) dut_i (
    .clk       (clk),
    .reset     (reset),
    .frame_val (frame_val),
    .frame_rdy (frame_rdy),
    .frame_msg (frame_msg),
    .cfg_val   (cfg_val),
    .cfg_rdy   (cfg_rdy),
    .cfg_msg   (cfg_msg),
    .result_val(result_val),
    .result_rdy(result_rdy),
    .result_msg(result_msg)
  );

  bind frame_capture classifier_properties #(
    .MSG_W($bits(classifier_pkg::mag_item_t)), .N_BINS(N_BINS), .CHECK_HITS(1'b0)
  ) cap_props_i (
    .clk(clk), .reset(reset), .out_val(cap_val), .out_rdy(cap_rdy),
    .out_msg(cap_msg), .in_rdy(frame_rdy), .hit_count('0)
  );

  bind decision_unit classifier_properties #(
    .MSG_W($bits(classifier_pkg::decision_t)), .N_BINS(N_BINS)
  ) dec_props_i (
    .clk(clk), .reset(reset), .out_val(result_val), .out_rdy(result_rdy),
    .out_msg(result_msg), .in_rdy(item_rdy), .hit_count(hit_count)
  );

  always #10 clk = ~clk;

  //==============================
  // Reporting and compare tasks
  //==============================

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  function automatic int unsigned assertion_failures();
    return dut_i.capture_i.cap_props_i.fail_count + dut_i.decide_i.dec_props_i.fail_count;
  endfunction

  always @(negedge clk) begin
    if (assertion_failures() != 0) begin
      stop_with_failure("A bound handshake assertion failed");
    end
  end

  task automatic compare_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s: got %b, expected %b", $time, what, got, exp);
      stop_with_failure("Stopping at the first mismatch");
    end
  endtask

  task automatic compare_decision(input decision_t got, input decision_t exp,
                                  input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s: got detected=%b hits=%0d peak=%0d, expected %b %0d %0d",
               $time, what, got.detected, got.hit_count, got.peak_index,
               exp.detected, exp.hit_count, exp.peak_index);
      stop_with_failure("Stopping at the first mismatch");
    end
  endtask

  //==============================
  // Reference model
  //==============================

  function automatic int abs_part(input logic signed [DATA_W-1:0] v);
    int x;
    x = int'(v);
    x = (x < 0) ? -x : x;
    return (x > 32767) ? 32767 : x;
  endfunction

  function automatic decision_t make_decision(input int hits, input int peak);
    decision_t d;
    d.detected   = (hits != 0);
    d.hit_count  = (BIN_IDX_W+1)'(hits);
    d.peak_index = BIN_IDX_W'(peak);
    return d;
  endfunction

  function automatic decision_t model_decision(input cfg_t c, input frame_t f);
    int a;
    int b;
    int mag;
    int hits;
    int best_mag;
    int best_idx;
    hits     = 0;
    best_mag = 0;
    best_idx = 0;
    for (int i = 0; i < N_BINS; i++) begin
      a   = abs_part(f[i].re);
      b   = abs_part(f[i].im);
      mag = (a >= b) ? a + b / 2 : b + a / 2;
      // Bin centre is i * fs / N
      if ((int'(c.sampling_freq) / N_BINS) * i >= int'(c.cutoff_freq) &&
          mag > int'(c.cutoff_mag)) begin
        hits = hits + 1;
        if (hits == 1 || mag > best_mag) begin
          best_mag = mag;
          best_idx = i;
        end
      end
    end
    return make_decision(hits, best_idx);
  endfunction

  function automatic frame_t random_frame();
    frame_t f;
    for (int i = 0; i < N_BINS; i++) begin
      f[i].re = 16'($urandom);
      f[i].im = 16'($urandom);
    end
    return f;
  endfunction

  function automatic cfg_t make_cfg(input int fs, input int cf, input int cm);
    cfg_t c;
    c.sampling_freq = 16'(fs);
    c.cutoff_freq   = 16'(cf);
    c.cutoff_mag    = 16'(cm);
    return c;
  endfunction

  //==============================
  // Channel tasks
  //==============================

  task automatic next_drive_slot();
    @(posedge clk);
    #1;
  endtask

  task automatic send_cfg(input cfg_t c);
    int waited;
    next_drive_slot();
    cfg_val = 1'b1;
    cfg_msg = c;
    waited  = 0;
    @(negedge clk);
    while (!cfg_rdy) begin
      waited = waited + 1;
      if (waited > TIMEOUT) begin
        stop_with_failure("Timed out waiting for cfg_rdy");
      end
      @(negedge clk);
    end
    next_drive_slot();
    cfg_val = 1'b0;
    cur_cfg = c;
  endtask

  task automatic send_frame(input frame_t f);
    int waited;
    next_drive_slot();
    frame_val = 1'b1;
    frame_msg = f;
    waited    = 0;
    @(negedge clk);
    while (!frame_rdy) begin
      waited = waited + 1;
      if (waited > TIMEOUT) begin
        stop_with_failure("Timed out waiting for frame_rdy");
      end
      @(negedge clk);
    end
    next_drive_slot();
    frame_val = 1'b0;
  endtask

  // Checks the decision while result_rdy is low, then takes it
  task automatic expect_result(input decision_t exp, input string what);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!result_val) begin
      waited = waited + 1;
      if (waited > TIMEOUT) begin
        stop_with_failure("Timed out waiting for result_val");
      end
      @(negedge clk);
    end
    compare_decision(result_msg, exp, what);
    next_drive_slot();
    result_rdy = 1'b1;
    next_drive_slot();
    result_rdy = 1'b0;
  endtask

  //==============================
  // Directed tests
  //==============================

  task automatic test_reset_and_zero();
    @(negedge clk);
    compare_bit(frame_rdy, 1'b1, "frame_rdy after reset");
    compare_bit(result_val, 1'b0, "result_val after reset");
    compare_bit(cfg_rdy, 1'b1, "cfg_rdy after reset");
    send_frame('0);
    expect_result(make_decision(0, 0), "all-zero frame");
  endtask

  task automatic test_highpass();
    frame_t f;
    f         = '0;
    f[1].re   = 16'sd5000;
    f[5].re   = 16'sd2000;
    f[5].im   = -16'sd1000;
    send_cfg(make_cfg(8000, 3000, 100));
    send_frame(f);
    expect_result(make_decision(1, 5), "highpass");
  endtask

  task automatic test_magnitude();
    frame_t f;
    f       = '0;
    f[0].re = 16'sd800;
    f[0].im = -16'sd400;
    f[1].re = -16'sd800;
    f[1].im = 16'sd401;
    f[2].re = 16'sd801;
    f[2].im = -16'sd400;
    f[3].re = -16'sd800;
    f[3].im = 16'sd402;
    send_cfg(make_cfg(8000, 0, 1000));
    send_frame(f);
    expect_result(make_decision(2, 2), "magnitude at and above threshold");
    f       = '0;
    f[0].re = 16'sh8000;
    f[1].im = 16'sh8000;
    f[4].re = 16'sh8000;
    f[4].im = 16'sd3;
    f[6].re = 16'sh8000;
    f[6].im = 16'sh8000;
    send_cfg(make_cfg(8000, 0, 32767));
    send_frame(f);
    expect_result(make_decision(2, 6), "most negative parts");
  endtask

  task automatic test_backpressure();
    frame_t f1;
    frame_t f2;
    f1 = random_frame();
    f2 = random_frame();
    send_cfg(make_cfg(16000, 2000, 20000));
    send_frame(f1);
    send_frame(f2);
    repeat (40) @(posedge clk);
    @(negedge clk);
    compare_bit(result_val, 1'b1, "result held under back-pressure");
    compare_bit(frame_rdy, 1'b0, "producer stalled behind full FIFO");
    expect_result(model_decision(cur_cfg, f1), "first frame under back-pressure");
    expect_result(model_decision(cur_cfg, f2), "second frame under back-pressure");
  endtask

  task automatic test_reconfig();
    frame_t f;
    f       = '0;
    f[2].re = 16'sd100;
    f[6].im = -16'sd100;
    send_cfg(make_cfg(8000, 0, 50));
    send_frame(f);
    expect_result(make_decision(2, 2), "frame before new configuration");
    send_cfg(make_cfg(8000, 5000, 50));
    send_frame(f);
    expect_result(make_decision(1, 6), "frame after new configuration");
  endtask

  task automatic test_random();
    frame_t f;
    for (int n = 0; n < 12; n++) begin
      send_cfg(make_cfg(int'($urandom_range(0, 65535)), int'($urandom_range(0, 60000)),
                        int'($urandom_range(0, 45000))));
      f = random_frame();
      send_frame(f);
      expect_result(model_decision(cur_cfg, f), "random frame");
    end
  endtask

  initial begin
    void'($urandom(32'hf820));
    reset      = 1'b1;
    frame_val  = 1'b0;
    frame_msg  = '0;
    cfg_val    = 1'b0;
    cfg_msg    = '0;
    result_rdy = 1'b0;
    cur_cfg    = '0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    test_reset_and_zero();
    test_highpass();
    test_magnitude();
    test_backpressure();
    test_reconfig();
    test_random();
    repeat (2) @(posedge clk);
    if (assertion_failures() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      stop_with_failure("Bound handshake assertions failed during the run");
    end
  end

endmodule

// File: test/classifier_properties.sv
//==============================
// Handshake and reset checks, bound into the
// producer and the consumer of the tone classifier
//==============================

`timescale 1ns/1ps

module classifier_properties import classifier_pkg::*; #(
  parameter int MSG_W      = 1,
  parameter int N_BINS     = 8,
  parameter bit CHECK_HITS = 1'b1
) (
  input logic               clk,
  input logic               reset,
  input logic               out_val,
  input logic               out_rdy,
  input logic [MSG_W-1:0]   out_msg,
  input logic               in_rdy,
  input logic [BIN_IDX_W:0] hit_count
);

  int unsigned fail_count = 0;

  // Stalled output keeps valid and payload
  held_payload: assert property (@(posedge clk) disable iff (reset)
    out_val && !out_rdy |=> out_val && $stable(out_msg))
    else begin
      $error("output payload changed before its transfer");
      fail_count = fail_count + 1;
    end

  // First cycle out of reset
  reset_state: assert property (@(posedge clk)
    $past(reset) && !reset |-> in_rdy && !out_val)
    else begin
      $error("handshake signals not at their reset values");
      fail_count = fail_count + 1;
    end

  // Only the consumer keeps a hit counter
  if (CHECK_HITS) begin : g_hits
    hits_bounded: assert property (@(posedge clk) disable iff (reset)
      hit_count <= (BIN_IDX_W+1)'(N_BINS))
      else begin
        $error("hit_count larger than the number of bins");
        fail_count = fail_count + 1;
      end
  end

endmodule

// File: source/classifier_top.sv
//==============================
// Tone classifier top level, producer to FIFO to consumer
//==============================

`timescale 1ns/1ps

module classifier_top import classifier_pkg::*; #(
  parameter int N_BINS     = 8,
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              reset,

  input  logic              frame_val,
  output logic              frame_rdy,
  input  bin_t [N_BINS-1:0] frame_msg,

  input  logic              cfg_val,
  output logic              cfg_rdy,
  input  cfg_t              cfg_msg,

  output logic              result_val,
  input  logic              result_rdy,
  output decision_t         result_msg
);

  // Producer to FIFO
  logic      cap_val;
  logic      cap_rdy;
  mag_item_t cap_msg;

  // FIFO to consumer
  logic      item_val;
  logic      item_rdy;
  mag_item_t item_msg;

  frame_capture #(
    .N_BINS(N_BINS)
  ) capture_i (
    .clk      (clk),
    .reset    (reset),
    .frame_val(frame_val),
    .frame_rdy(frame_rdy),
    .frame_msg(frame_msg),
    .cap_val  (cap_val),
    .cap_rdy  (cap_rdy),
    .cap_msg  (cap_msg)
  );

  bin_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) fifo_i (
    .clk    (clk),
    .reset  (reset),
    .in_val (cap_val),
    .in_rdy (cap_rdy),
    .in_msg (cap_msg),
    .out_val(item_val),
    .out_rdy(item_rdy),
    .out_msg(item_msg)
  );

  decision_unit #(
    .N_BINS(N_BINS)
  ) decide_i (
    .clk       (clk),
    .reset     (reset),
    .cfg_val   (cfg_val),
    .cfg_rdy   (cfg_rdy),
    .cfg_msg   (cfg_msg),
    .item_val  (item_val),
    .item_rdy  (item_rdy),
    .item_msg  (item_msg),
    .result_val(result_val),
    .result_rdy(result_rdy),
    .result_msg(result_msg)
  );

endmodule

// File: source/decision_unit.sv
//==============================
// Consumer stage, highpass and threshold test per bin
// and one tone decision per frame
//==============================

`timescale 1ns/1ps

module decision_unit import classifier_pkg::*; #(
  parameter int N_BINS = 8
) (
  input  logic      clk,
  input  logic      reset,

  input  logic      cfg_val,
  output logic      cfg_rdy,
  input  cfg_t      cfg_msg,

  input  logic      item_val,
  output logic      item_rdy,
  input  mag_item_t item_msg,

  output logic      result_val,
  input  logic      result_rdy,
  output decision_t result_msg
);

  localparam int LOG2_N = $clog2(N_BINS);
  localparam int FREQ_W = DATA_W + BIN_IDX_W;

  decide_state_e        state;
  cfg_t                 cfg_q;
  logic [DATA_W-1:0]    step;
  logic [FREQ_W-1:0]    bin_freq;
  logic                 freq_ok;
  logic                 mag_ok;
  logic                 take;
  logic [BIN_IDX_W:0]   hit_count;
  logic [BIN_IDX_W-1:0] peak_index;
  logic [DATA_W-1:0]    peak_mag;

  assign cfg_rdy    = 1'b1;
  assign item_rdy   = (state == COLLECT);
  assign result_val = (state == REPORT);

  // Configuration stays until the next transfer
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg_q <= '0;
    end else if (cfg_val) begin
      cfg_q <= cfg_msg;
    end
  end

  //==============================
  // Per-bin tests
  //==============================

  // Bin spacing is fs / N
  assign step     = cfg_q.sampling_freq >> LOG2_N;
  assign bin_freq = FREQ_W'(step) * FREQ_W'(item_msg.index);
  assign freq_ok  = (bin_freq >= FREQ_W'(cfg_q.cutoff_freq));
  assign mag_ok   = (item_msg.mag > cfg_q.cutoff_mag);
  assign take     = item_val && item_rdy;

  //==============================
  // Accumulate and report
  //==============================

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= COLLECT;
      hit_count  <= '0;
      peak_index <= '0;
      peak_mag   <= '0;
    end else begin
      case (state)
        COLLECT: begin
          if (take) begin
            if (freq_ok && mag_ok) begin
              hit_count <= hit_count + 1'b1;
              // Bins arrive in index order so a tie keeps the lower one
              if (hit_count == '0 || item_msg.mag > peak_mag) begin
                peak_index <= item_msg.index;
                peak_mag   <= item_msg.mag;
              end
            end
            if (item_msg.last) begin
              state <= REPORT;
            end
          end
        end
        REPORT: begin
          if (result_rdy) begin
            state      <= COLLECT;
            hit_count  <= '0;
            peak_index <= '0;
            peak_mag   <= '0;
          end
        end
        default: state <= COLLECT;
      endcase
    end
  end

  always_comb begin
    result_msg.detected   = (hit_count != '0);
    result_msg.hit_count  = hit_count;
    result_msg.peak_index = peak_index;
  end

endmodule

// File: source/bin_fifo.sv
//==============================
// Circular valid/ready FIFO of magnitude items
// between the producer and the decision stage
//==============================

`timescale 1ns/1ps

module bin_fifo import classifier_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic      clk,
  input  logic      reset,

  input  logic      in_val,
  output logic      in_rdy,
  input  mag_item_t in_msg,

  output logic      out_val,
  input  logic      out_rdy,
  output mag_item_t out_msg
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  mag_item_t        mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_wr;
  logic             do_rd;

  assign in_rdy  = (count != (PTR_W+1)'(FIFO_DEPTH));
  assign out_val = (count != '0);
  assign out_msg = mem[rd_ptr];

  assign do_wr = in_val && in_rdy;
  assign do_rd = out_val && out_rdy;

  // Storage
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= in_msg;
    end
  end

  //==============================
  // Pointers and occupancy
  //==============================

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous read and write leaves count unchanged
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: source/frame_capture.sv
//==============================
// Producer stage, registers one spectrum frame
// and streams a magnitude item per bin to the FIFO
//==============================

`timescale 1ns/1ps

module frame_capture import classifier_pkg::*; #(
  parameter int N_BINS = 8
) (
  input  logic                   clk,
  input  logic                   reset,

  input  logic                   frame_val,
  output logic                   frame_rdy,
  input  bin_t [N_BINS-1:0]      frame_msg,

  output logic                   cap_val,
  input  logic                   cap_rdy,
  output mag_item_t              cap_msg
);

  localparam int IDX_W = (N_BINS > 1) ? $clog2(N_BINS) : 1;

  capture_state_e    state;
  bin_t [N_BINS-1:0] frame_q;
  logic [IDX_W-1:0]  idx;
  bin_t              cur_bin;
  logic              is_last;
  logic [DATA_W-1:0] abs_re;
  logic [DATA_W-1:0] abs_im;
  logic [DATA_W-1:0] mag_hi;
  logic [DATA_W-1:0] mag_lo;

  // Most negative input saturates to the largest positive value
  function automatic logic [DATA_W-1:0] abs_sat(input logic signed [DATA_W-1:0] v);
    logic [DATA_W-1:0] r;
    if (v == {1'b1, {(DATA_W-1){1'b0}}}) begin
      r = {1'b0, {(DATA_W-1){1'b1}}};
    end else if (v < 0) begin
      r = -v;
    end else begin
      r = v;
    end
    return r;
  endfunction

  assign frame_rdy = (state == IDLE);
  assign cap_val   = (state == STREAM);

  // Frame payload
  always_ff @(posedge clk) begin
    if (frame_val && frame_rdy) begin
      frame_q <= frame_msg;
    end
  end

  //==============================
  // Magnitude approximation
  //==============================

  assign cur_bin = frame_q[idx];
  assign is_last = (idx == IDX_W'(N_BINS - 1));

  always_comb begin
    abs_re = abs_sat(cur_bin.re);
    abs_im = abs_sat(cur_bin.im);
    if (abs_re >= abs_im) begin
      mag_hi = abs_re;
      mag_lo = abs_im;
    end else begin
      mag_hi = abs_im;
      mag_lo = abs_re;
    end
    cap_msg.index = BIN_IDX_W'(idx);
    cap_msg.mag   = mag_hi + (mag_lo >> 1);
    cap_msg.last  = is_last;
  end

  //==============================
  // Bin walk FSM
  //==============================

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      idx   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (frame_val) begin
            state <= STREAM;
            idx   <= '0;
          end
        end
        STREAM: begin
          // Item held until the FIFO takes it
          if (cap_rdy) begin
            if (is_last) begin
              state <= IDLE;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: source/classifier_pkg.sv
//==============================
// Shared widths and types for the tone classifier
// Imported by every RTL block of the subsystem
//==============================

package classifier_pkg;

  //==============================
  // Widths
  //==============================

  // Real, imaginary, frequency and magnitude width
  parameter int DATA_W = 16;

  // Bin index width, up to 64 bins per frame
  parameter int BIN_IDX_W = 6;

  //==============================
  // Channel payloads
  //==============================

  typedef struct packed {
    logic signed [DATA_W-1:0] re;
    logic signed [DATA_W-1:0] im;
  } bin_t;

  typedef struct packed {
    logic [DATA_W-1:0] sampling_freq;
    logic [DATA_W-1:0] cutoff_freq;
    logic [DATA_W-1:0] cutoff_mag;
  } cfg_t;

  typedef struct packed {
    logic [BIN_IDX_W-1:0] index;
    logic [DATA_W-1:0]    mag;
    logic                 last;
  } mag_item_t;

  typedef struct packed {
    logic                 detected;
    logic [BIN_IDX_W:0]   hit_count;
    logic [BIN_IDX_W-1:0] peak_index;
  } decision_t;

  // FSM states
  typedef enum logic {IDLE, STREAM} capture_state_e;
  typedef enum logic {COLLECT, REPORT} decide_state_e;

endpackage
